// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module tb_metricMaxFinder -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Errors found" sim.log; then
   echo "simulation failed"
   exit 1
fi
if [ $runStatus -ne 0 ]; then
   echo "simulation exited with status $runStatus"
   exit 1
fi

echo "simulation passed"
exit 0

// ==== sim/metricMaxFinder_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module metricMaxFinderChecks (
   input wire logic clk,
   input wire logic reset,
   input wire logic pushReq,                                // write request into the FIFO
   input wire logic isFull,
   input wire logic resultValid
);

   // the packer has to see full before it offers a beat
   noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
      !(pushReq && isFull))
      else $error("beat offered to a full FIFO");

   resultOneCycle: assert property (@(posedge clk) disable iff (reset)
      resultValid |=> !resultValid)
      else $error("resultValid held for more than one cycle");

   resultLowAfterReset: assert property (@(posedge clk) reset |=> !resultValid)
      else $error("resultValid high right after reset");

endmodule

bind metricFifo metricMaxFinderChecks fifoChecks (
   .clk         (clk),
   .reset       (reset),
   .pushReq     (inIf.valid),
   .isFull      (full),
   .resultValid (1'b0)                                      // no result in the FIFO
);

bind bestPathSearch metricMaxFinderChecks searchChecks (
   .clk         (clk),
   .reset       (reset),
   .pushReq     (1'b0),
   .isFull      (1'b0),
   .resultValid (resultValid)
);

`default_nettype wire

// ==== sim/tb_metricMaxFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "metric_macros.svh"

module tb_metricMaxFinder
   import metricPkg::*;
   import searchPkg::*;
();

   localparam int numStates = `NUM_GROUPS * 4;
   localparam int quarter   = 2 ** (`METRIC_WIDTH - 2);      // normalization step
   localparam int kindRamp    = 0;
   localparam int kindScatter = 1;
   localparam int kindMixed   = 2;
   localparam int kindNeg     = 3;
   localparam int kindTie     = 4;
   localparam int kindFlat    = 5;
   localparam int kindRand    = 6;

   logic     clk;
   logic     reset;
   logic     metricValid;
   logic     frameStart;
   logic     normalize;
   logic     resultValid;
   logic     overflow;
   metricT   metricA;
   metricT   metricB;
   metricT   metricC;
   metricT   metricD;
   metricT   bestMetric;
   stateIdxT bestIndex;

   metricT      frameVals [numStates];                      // one frame, state order
   logic [31:0] lfsrState = 32'd96606;
   int          cycleCount = 0;
   int          cycleLimit;
   string       rowName [$];
   int          rowKind [$];
   int          rowAbort [$];                               // beats sent before a restart
   logic        rowNorm [$];
   logic        rowGaps [$];

   metricMaxFinder DUT (
      .clk         (clk),
      .reset       (reset),
      .metricValid (metricValid),
      .frameStart  (frameStart),
      .normalize   (normalize),
      .metricA     (metricA),
      .metricB     (metricB),
      .metricC     (metricC),
      .metricD     (metricD),
      .resultValid (resultValid),
      .bestIndex   (bestIndex),
      .bestMetric  (bestMetric),
      .overflow    (overflow)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount > cycleLimit) begin
         $display("timeout: no result arrived within %0d cycles", cycleLimit);
         stopWithFailure();
      end
   end

   task automatic stopWithFailure();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic checkValue(string what, logic signed [31:0] expected,
                             logic signed [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s: expected %0d, actual %0d", what, expected, actual);
         stopWithFailure();
      end
   endtask

   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois with right shift
   endfunction

   function automatic logic [31:0] randomBits(int n);
      logic [31:0] value;
      value = '0;
      for (int k = 0; k < n; k++) begin
         value = {value[30:0], lfsrState[0]};
         lfsrState = lfsrStep(lfsrState);                  // one step per bit
      end
      return value;
   endfunction

   function automatic int fixedValue(int kind, int i);
      case (kind)
         kindRamp:    fixedValue = i + 1;                   // peak at state 63
         kindScatter: fixedValue = (i * 37) % 101;
         kindMixed:   fixedValue = ((i * 29 + 11) % 256) - 128;
         kindNeg:     fixedValue = -100 + ((i * 41) % 64);
         kindTie:     fixedValue = (i == 9 || i == 10 || i == 37 || i == 60) ? 50 : i % 20;
         default:     fixedValue = -100;                    // flat frame
      endcase
   endfunction

   task automatic addRow(string name, int kind, logic norm, logic gaps, int abortBeats);
      rowName.push_back(name);
      rowKind.push_back(kind);
      rowNorm.push_back(norm);
      rowGaps.push_back(gaps);
      rowAbort.push_back(abortBeats);
   endtask

   task automatic loadTable();
      addRow("posRamp", kindRamp, 1'b0, 1'b0, 0);
      addRow("posScatter", kindScatter, 1'b0, 1'b1, 0);
      addRow("mixedSign", kindMixed, 1'b0, 1'b0, 0);
      addRow("allNegative", kindNeg, 1'b0, 1'b1, 0);
      addRow("tieLowest", kindTie, 1'b0, 1'b0, 0);
      addRow("flatNegative", kindFlat, 1'b0, 1'b0, 0);
      addRow("normRamp", kindRamp, 1'b1, 1'b0, 0);
      addRow("normWrap", kindFlat, 1'b1, 1'b1, 0);
      addRow("randGaps", kindRand, 1'b0, 1'b1, 0);
      addRow("randBurst", kindRand, 1'b0, 1'b0, 0);
      addRow("randNorm", kindRand, 1'b1, 1'b0, 0);
      addRow("restartMid", kindRand, 1'b0, 1'b0, 7);
      addRow("restartGaps", kindScatter, 1'b1, 1'b1, 3);
      // per row at most 15 aborted beats, 48 beat cycles and the result latency
      cycleLimit = 10 + rowName.size() * ((`NUM_GROUPS - 1) + 3 * `NUM_GROUPS + 10);
   endtask

   task automatic buildFrame(int kind);
      for (int i = 0; i < numStates; i++) begin
         if (kind == kindRand)
            frameVals[i] = metricT'(randomBits(`METRIC_WIDTH));
         else
            frameVals[i] = metricT'(fixedValue(kind, i));
      end
   endtask

   // highest signed value, first index on ties, optional quarter-range drop
   task automatic computeExpected(input logic norm, output int idx, output int value);
      int bestVal;
      bestVal = int'(frameVals[0]);
      idx = 0;
      for (int i = 1; i < numStates; i++) begin
         if (int'(frameVals[i]) > bestVal) begin
            bestVal = int'(frameVals[i]);
            idx = i;
         end
      end
      value = norm ? int'(metricT'(bestVal - quarter)) : bestVal;
   endtask

   task automatic applyBeat(logic start, logic norm, metricT a, metricT b, metricT c,
                            metricT d);
      metricValid = 1'b1;
      frameStart  = start;
      normalize   = norm;
      metricA     = a;
      metricB     = b;
      metricC     = c;
      metricD     = d;
   endtask

   task automatic idleInputs();
      metricValid = 1'b0;
      frameStart  = 1'b0;
   endtask

   task automatic runRow(int r);
      int expIdx;
      int expVal;
      buildFrame(rowKind[r]);
      computeExpected(rowNorm[r], expIdx, expVal);
      for (int g = 0; g < rowAbort[r]; g++) begin          // would win if not discarded
         @(negedge clk);
         applyBeat(g == 0, 1'b0, 8'sd127, 8'sd127, 8'sd127, 8'sd127);
      end
      for (int g = 0; g < `NUM_GROUPS; g++) begin
         @(negedge clk);
         applyBeat(g == 0, rowNorm[r], frameVals[4*g], frameVals[4*g+1],
                   frameVals[4*g+2], frameVals[4*g+3]);
         if (rowGaps[r]) begin
            repeat (1 + g % 2) begin
               @(negedge clk);
               idleInputs();
            end
         end
      end
      @(negedge clk);
      idleInputs();
      while (!resultValid) @(negedge clk);
      checkValue({rowName[r], " index"}, expIdx, bestIndex);
      checkValue({rowName[r], " metric"}, expVal, bestMetric);
      checkValue({rowName[r], " overflow"}, 0, overflow);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      normalize = 1'b0;
      idleInputs();
      {metricA, metricB, metricC, metricD} = '0;
      loadTable();
      repeat (2) @(negedge clk);
      reset = 1'b0;
      foreach (rowName[r]) runRow(r);
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/bestPathSearch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "metric_macros.svh"

module bestPathSearch
   import metricPkg::*;
   import searchPkg::*;
(
   input  logic     clk,
   input  logic     reset,
   quadIf.sink      inIf,
   output logic     resultValid,
   output stateIdxT bestIndex,
   output metricT   bestMetric
);

   // a quarter of the metric range
   localparam metricT normStep = metricT'(2 ** (`METRIC_WIDTH - 2));

   resultT groupBest;                                       // selector output
   resultT runBest;                                         // best so far in frame
   resultT newBest;
   logic   selValid;
   logic   selFirst;
   logic   selLast;
   logic   selNorm;

   assign inIf.pop  = inIf.valid;                           // always accepts
   assign inIf.full = 1'b0;

   quadMaxSelect u_select (
      .clk   (clk),
      .reset (reset),
      .ce    (inIf.pop),
      .beat  (inIf.beat),
      .best  (groupBest)
   );

   // flags travel beside the selector stage
   always_ff @(posedge clk) begin
      if (reset) begin
         selValid <= 1'b0;
         selFirst <= 1'b0;
         selLast  <= 1'b0;
         selNorm  <= 1'b0;
      end else begin
         selValid <= inIf.pop;
         selFirst <= (inIf.beat.group == '0);
         selLast  <= inIf.beat.last;
         selNorm  <= inIf.beat.normalize;
      end
   end

   // first group replaces, later groups only when strictly larger
   always_comb begin
      if (selFirst || (groupBest.metric > runBest.metric))
         newBest = groupBest;
      else
         newBest = runBest;
   end

   always_ff @(posedge clk) begin
      if (selValid)
         runBest <= newBest;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         resultValid <= 1'b0;
      end else begin
         resultValid <= selValid && selLast;                // one pulse per frame
      end
   end

   always_ff @(posedge clk) begin
      if (selValid && selLast) begin
         bestIndex  <= newBest.index;
         bestMetric <= selNorm ? metricT'(newBest.metric - normStep) : newBest.metric;
      end
   end

endmodule

`default_nettype wire

// ==== src/metricFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "metric_macros.svh"

module metricFifo
   import metricPkg::*;
#(
   parameter type payloadT = quadT
) (
   input  logic  clk,
   input  logic  reset,
   quadIf.sink   inIf,
   quadIf.source outIf
);

   localparam int ptrW = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
   localparam logic [ptrW-1:0] lastPtr = ptrW'(`FIFO_DEPTH - 1);
   localparam logic [ptrW:0] depthCnt = (ptrW+1)'(`FIFO_DEPTH);

   payloadT mem [`FIFO_DEPTH];                              // beat storage

   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [ptrW:0]   count;                                  // occupancy
   logic            full;
   logic            push;
   logic            pop;

   assign full = (count == depthCnt);
   assign push = inIf.valid && !full;
   assign pop  = outIf.pop && (count != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push)
            wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
         if (pop)
            rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                        // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wrPtr] <= inIf.beat;
   end

   assign inIf.full  = full;
   assign inIf.pop   = push;                                // accepted write
   assign outIf.valid = (count != '0);
   assign outIf.beat  = mem[rdPtr];                         // head shown while non-empty

endmodule

`default_nettype wire

// ==== src/metricMaxFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module metricMaxFinder
   import metricPkg::*;
   import searchPkg::*;
(
   input  wire logic     clk,
   input  wire logic     reset,
   input  wire logic     metricValid,
   input  wire logic     frameStart,
   input  wire logic     normalize,
   input  wire metricT   metricA,
   input  wire metricT   metricB,
   input  wire metricT   metricC,
   input  wire metricT   metricD,
   output logic          resultValid,
   output stateIdxT      bestIndex,
   output metricT        bestMetric,
   output logic          overflow
);

   quadIf packIf ();                                        // packer to buffer
   quadIf searchIf ();                                      // buffer to search

   metricPacker u_packer (
      .clk         (clk),
      .reset       (reset),
      .metricValid (metricValid),
      .frameStart  (frameStart),
      .normalize   (normalize),
      .metricA     (metricA),
      .metricB     (metricB),
      .metricC     (metricC),
      .metricD     (metricD),
      .overflow    (overflow),
      .outIf       (packIf.source)
   );

   metricFifo #(
      .payloadT (quadT)
   ) u_fifo (
      .clk   (clk),
      .reset (reset),
      .inIf  (packIf.sink),
      .outIf (searchIf.source)
   );

   bestPathSearch u_search (
      .clk         (clk),
      .reset       (reset),
      .inIf        (searchIf.sink),
      .resultValid (resultValid),
      .bestIndex   (bestIndex),
      .bestMetric  (bestMetric)
   );

endmodule

`default_nettype wire

// ==== src/metricPacker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "metric_macros.svh"

module metricPacker
   import metricPkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   metricValid,
   input  logic   frameStart,
   input  logic   normalize,
   input  metricT metricA,
   input  metricT metricB,
   input  metricT metricC,
   input  metricT metricD,
   output logic   overflow,
   quadIf.source  outIf
);

   localparam groupT lastGroup = groupT'(`NUM_GROUPS - 1);

   groupT groupCnt;                                         // next expected group
   groupT curGroup;
   logic  beatValid;
   quadT  beatReg;

   assign curGroup = frameStart ? '0 : groupCnt;            // frameStart restarts numbering

   always_ff @(posedge clk) begin
      if (reset) begin
         groupCnt  <= '0;
         beatValid <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         beatValid <= metricValid && !outIf.full;
         if (metricValid) begin
            groupCnt <= curGroup + 1'b1;                    // wraps after last group
            if (outIf.full)
               overflow <= 1'b1;                            // sticky flag for a dropped beat
         end
      end
   end

   // beat payload meaningful only while beatValid
   always_ff @(posedge clk) begin
      if (metricValid) begin
         beatReg.a         <= metricA;
         beatReg.b         <= metricB;
         beatReg.c         <= metricC;
         beatReg.d         <= metricD;
         beatReg.group     <= curGroup;
         beatReg.last      <= (curGroup == lastGroup);
         beatReg.normalize <= normalize;
      end
   end

   assign outIf.valid = beatValid;
   assign outIf.beat  = beatReg;

endmodule

`default_nettype wire

// ==== src/metricPkg.sv ====
`default_nettype none

`include "metric_macros.svh"

package metricPkg;

   typedef logic signed [`METRIC_WIDTH-1:0] metricT;       // one path metric

   typedef logic [$clog2(`NUM_GROUPS)-1:0] groupT;          // beat number in frame

   // one beat of four metrics plus its tag
   typedef struct packed {
      metricT a;                                            // position 0
      metricT b;                                            // position 1
      metricT c;                                            // position 2
      metricT d;                                            // position 3
      groupT  group;
      logic   last;                                         // final beat of frame
      logic   normalize;                                    // only looked at on last beat
   } quadT;

endpackage

`default_nettype wire

// ==== src/metric_macros.svh ====
`ifndef METRIC_MACROS_SVH
`define METRIC_MACROS_SVH

// width of one signed path metric
`define METRIC_WIDTH 8

// beats in one frame, four states per beat, 64 states total
`define NUM_GROUPS 16

// entries in the beat buffer between packer and search
`define FIFO_DEPTH 4

`endif

// ==== src/quadIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface quadIf
   import metricPkg::*;
();

   logic valid;                                             // beat present this cycle
   quadT beat;
   logic full;                                              // receiver cannot take more
   logic pop;                                               // receiver takes the beat

   modport source (
      output valid,
      output beat,
      input  full,
      input  pop
   );

   // the receiving side also reports its fill state upstream
   modport sink (
      input  valid,
      input  beat,
      output pop,
      output full
   );

endinterface

`default_nettype wire

// ==== src/quadMaxSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module quadMaxSelect
   import metricPkg::*;
   import searchPkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   ce,
   input  quadT   beat,
   output resultT best
);

   localparam int msb = $bits(metricT) - 1;

   // high when b is strictly larger than a as two's complement
   function automatic logic bWins(metricT a, metricT b);
      logic [1:0] signs;
      signs = {a[msb], b[msb]};
      case (signs)
         2'b01:   bWins = 1'b0;                              // a positive and b negative
         2'b10:   bWins = 1'b1;                              // a negative and b positive
         default: bWins = ($unsigned(b) > $unsigned(a));    // same sign keeps raw bit order
      endcase
   endfunction

   logic       selAB;
   logic       selCD;
   logic       selFinal;
   metricT     winAB;
   metricT     winCD;
   metricT     winMetric;
   logic [1:0] posAB;
   logic [1:0] posCD;
   logic [1:0] winPos;

   // pairwise tournament where ties keep the lower position
   always_comb begin
      selAB     = bWins(beat.a, beat.b);
      winAB     = selAB ? beat.b : beat.a;
      posAB     = selAB ? 2'd1 : 2'd0;
      selCD     = bWins(beat.c, beat.d);
      winCD     = selCD ? beat.d : beat.c;
      posCD     = selCD ? 2'd3 : 2'd2;
      selFinal  = bWins(winAB, winCD);
      winMetric = selFinal ? winCD : winAB;
      winPos    = selFinal ? posCD : posAB;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         best <= '0;
      end else if (ce) begin
         best.index  <= {beat.group, winPos};               // group times four plus position
         best.metric <= winMetric;
      end
   end

endmodule

`default_nettype wire

// ==== src/searchPkg.sv ====
`default_nettype none

package searchPkg;

   import metricPkg::*;

   // group number in the upper bits, position in the lower two
   typedef logic [$bits(groupT)+1:0] stateIdxT;

   typedef struct packed {
      stateIdxT index;                                      // winning state
      metricT   metric;                                     // its path metric
   } resultT;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/metricPkg.sv
src/searchPkg.sv
src/quadIf.sv
src/metricPacker.sv
src/metricFifo.sv
src/quadMaxSelect.sv
src/bestPathSearch.sv
src/metricMaxFinder.sv
sim/metricMaxFinder_assert.sv
sim/tb_metricMaxFinder.sv
